// ==== source/opl_timer_pkg.sv ====
// shared widths, register indices and bit positions for the timer section; referenced by scope
`default_nettype none

package opl_timer_pkg;

  // bus and counter widths
  localparam int DATA_W  = 8;
  localparam int COUNT_W = 8;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [COUNT_W-1:0] timer_count_t;

  // register indices that are actually stored
  localparam data_t REG_TIMER1     = 8'h02;
  localparam data_t REG_TIMER2     = 8'h03;
  localparam data_t REG_TIMER_CTRL = 8'h04;

  // control register fields
  localparam int CTRL_FLAG_RESET_BIT = 7;
  localparam int CTRL_MASK1_BIT      = 6;
  localparam int CTRL_MASK2_BIT      = 5;
  localparam int CTRL_START1_BIT     = 0;
  localparam int CTRL_START2_BIT     = 1;

  // status byte fields, everything else reads zero
  localparam int STATUS_IRQ_BIT   = 7;
  localparam int STATUS_FLAG1_BIT = 6;
  localparam int STATUS_FLAG2_BIT = 5;

  // timer 2 ticks this many times slower than timer 1
  localparam int TIMER2_TICK_RATIO = 4;

endpackage

`default_nettype wire

// ==== source/opl_bus_decode.sv ====
// host bus decoder: latches the register index, strobes data writes and drives read data
`default_nettype none

module opl_bus_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cs_n,
  input  logic                 wr_n,
  input  logic                 a0,
  input  opl_timer_pkg::data_t din,
  input  opl_timer_pkg::data_t status,
  output opl_timer_pkg::data_t dout,
  output logic                 reg_we,
  output opl_timer_pkg::data_t reg_index,
  output opl_timer_pkg::data_t reg_data
);

  logic                 write;
  logic                 read;
  logic                 index_we;
  opl_timer_pkg::data_t index;

  // strobe decode
  assign write    = !cs_n && !wr_n;
  assign read     = !cs_n && !a0;
  assign index_we = write && !a0;

  // index register, used from the next cycle on
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      index <= '0;
    end else if (index_we) begin
      index <= din;
    end
  end

  // data write goes straight through in the same cycle
  assign reg_we    = write && a0;
  assign reg_index = index;
  assign reg_data  = din;

  // status only appears on the bus while it is being read
  always_comb begin
    if (read) begin
      dout = status;
    end else begin
      dout = '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/opl_timer_regs.sv ====
// timer register block: presets, start and mask bits, and the flag reset command
`default_nettype none

module opl_timer_regs (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        reg_we,
  input  opl_timer_pkg::data_t        reg_index,
  input  opl_timer_pkg::data_t        reg_data,
  output opl_timer_pkg::timer_count_t preset1,
  output opl_timer_pkg::timer_count_t preset2,
  output logic                        start1,
  output logic                        start2,
  output logic                        mask1,
  output logic                        mask2,
  output logic                        flag_reset
);

  logic preset1_we;
  logic preset2_we;
  logic ctrl_we;
  logic reset_cmd;

  // index match, other indices are dropped
  assign preset1_we = reg_we && (reg_index == opl_timer_pkg::REG_TIMER1);
  assign preset2_we = reg_we && (reg_index == opl_timer_pkg::REG_TIMER2);
  assign ctrl_we    = reg_we && (reg_index == opl_timer_pkg::REG_TIMER_CTRL);

  // bit 7 turns a control write into a flag reset only
  assign reset_cmd  = reg_data[opl_timer_pkg::CTRL_FLAG_RESET_BIT];
  assign flag_reset = ctrl_we && reset_cmd;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      preset1 <= '0;
    end else if (preset1_we) begin
      preset1 <= reg_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      preset2 <= '0;
    end else if (preset2_we) begin
      preset2 <= reg_data;
    end
  end

  // start and mask bits, left alone by a flag reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start1 <= 1'b0;
      start2 <= 1'b0;
      mask1  <= 1'b0;
      mask2  <= 1'b0;
    end else if (ctrl_we && !reset_cmd) begin
      start1 <= reg_data[opl_timer_pkg::CTRL_START1_BIT];
      start2 <= reg_data[opl_timer_pkg::CTRL_START2_BIT];
      mask1  <= reg_data[opl_timer_pkg::CTRL_MASK1_BIT];
      mask2  <= reg_data[opl_timer_pkg::CTRL_MASK2_BIT];
    end
  end

endmodule

`default_nettype wire

// ==== source/opl_interval_timer.sv ====
// one interval timer: tick prescaler plus 8-bit up counter with preset reload and overflow pulse
`default_nettype none

module opl_interval_timer #(
  parameter int tick_clks = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  opl_timer_pkg::timer_count_t preset,
  output logic                        overflow
);

  // at least one bit even for a divide by one
  localparam int PRESC_W = (tick_clks > 1) ? $clog2(tick_clks) : 1;
  localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(tick_clks - 1);

  logic [PRESC_W-1:0]          presc;
  logic                        tick;
  logic                        at_top;
  opl_timer_pkg::timer_count_t count;

  assign tick   = start && (presc == PRESC_LAST);
  assign at_top = &count;

  // prescaler, parked at zero while stopped
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      presc <= '0;
    end else if (!start || tick) begin
      presc <= '0;
    end else begin
      presc <= presc + 1'b1;
    end
  end

  // counter follows the preset until started
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (!start) begin
      count <= preset;
    end else if (tick) begin
      if (at_top) begin
        count <= preset;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // single cycle pulse on wrap
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      overflow <= 1'b0;
    end else begin
      overflow <= tick && at_top;
    end
  end

endmodule

`default_nettype wire

// ==== source/opl_status_irq.sv ====
// overflow flags, status byte and active low interrupt for both timers
`default_nettype none

module opl_status_irq (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 overflow1,
  input  logic                 overflow2,
  input  logic                 mask1,
  input  logic                 mask2,
  input  logic                 flag_reset,
  output opl_timer_pkg::data_t status,
  output logic                 irq_n
);

  logic flag1;
  logic flag2;
  logic irq_set;

  // a masked timer still sets its flag
  assign irq_set = (overflow1 && !mask1) || (overflow2 && !mask2);

  // pulse beats a reset in the same cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      flag1 <= 1'b0;
      flag2 <= 1'b0;
    end else begin
      if (overflow1) begin
        flag1 <= 1'b1;
      end else if (flag_reset) begin
        flag1 <= 1'b0;
      end
      if (overflow2) begin
        flag2 <= 1'b1;
      end else if (flag_reset) begin
        flag2 <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      irq_n <= 1'b1;
    end else if (irq_set) begin
      irq_n <= 1'b0;
    end else if (flag_reset) begin
      irq_n <= 1'b1;
    end
  end

  // status byte, top bit is either flag
  always_comb begin
    status = '0;
    status[opl_timer_pkg::STATUS_IRQ_BIT]   = flag1 || flag2;
    status[opl_timer_pkg::STATUS_FLAG1_BIT] = flag1;
    status[opl_timer_pkg::STATUS_FLAG2_BIT] = flag2;
  end

endmodule

`default_nettype wire

// ==== source/opl_timer_top.sv ====
// timer section top level: bus decoder, register block, two timers and status/irq logic
`default_nettype none

module opl_timer_top #(
  parameter int tick_clks = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cs_n,
  input  logic                 wr_n,
  input  logic                 a0,
  input  opl_timer_pkg::data_t din,
  output opl_timer_pkg::data_t dout,
  output logic                 irq_n
);

  // timer 2 runs on a slower tick
  localparam int TIMER2_TICK_CLKS = tick_clks * opl_timer_pkg::TIMER2_TICK_RATIO;

  logic                        reg_we;
  opl_timer_pkg::data_t        reg_index;
  opl_timer_pkg::data_t        reg_data;
  opl_timer_pkg::data_t        status;
  opl_timer_pkg::timer_count_t preset1;
  opl_timer_pkg::timer_count_t preset2;
  logic                        start1;
  logic                        start2;
  logic                        mask1;
  logic                        mask2;
  logic                        flag_reset;
  logic                        overflow1;
  logic                        overflow2;

  opl_bus_decode bus_decode (
    .clk       (clk),
    .rst       (rst),
    .cs_n      (cs_n),
    .wr_n      (wr_n),
    .a0        (a0),
    .din       (din),
    .status    (status),
    .dout      (dout),
    .reg_we    (reg_we),
    .reg_index (reg_index),
    .reg_data  (reg_data)
  );

  opl_timer_regs timer_regs (
    .clk        (clk),
    .rst        (rst),
    .reg_we     (reg_we),
    .reg_index  (reg_index),
    .reg_data   (reg_data),
    .preset1    (preset1),
    .preset2    (preset2),
    .start1     (start1),
    .start2     (start2),
    .mask1      (mask1),
    .mask2      (mask2),
    .flag_reset (flag_reset)
  );

  opl_interval_timer #(.tick_clks(tick_clks)) timer1 (
    .clk      (clk),
    .rst      (rst),
    .start    (start1),
    .preset   (preset1),
    .overflow (overflow1)
  );

  opl_interval_timer #(.tick_clks(TIMER2_TICK_CLKS)) timer2 (
    .clk      (clk),
    .rst      (rst),
    .start    (start2),
    .preset   (preset2),
    .overflow (overflow2)
  );

  opl_status_irq status_irq (
    .clk        (clk),
    .rst        (rst),
    .overflow1  (overflow1),
    .overflow2  (overflow2),
    .mask1      (mask1),
    .mask2      (mask2),
    .flag_reset (flag_reset),
    .status     (status),
    .irq_n      (irq_n)
  );

endmodule

`default_nettype wire

// ==== bench/opl_timer_tb.sv ====
// testbench for opl_timer_top that applies a table of timer runs over the host bus, built from list.f
`default_nettype none

module opl_timer_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 5;
  localparam int DRIVE_DELAY   = 5;
  localparam int SAMPLE_DELAY  = 10;
  localparam int TICK_CLKS     = 4;
  localparam int T2_RATIO      = 4;
  localparam int NUM_ROWS      = 4;
  localparam int UNUSED_WRITES = 2;
  localparam int unsigned SEED = 98360;

  logic       clk;
  logic       rst;
  logic       cs_n;
  logic       wr_n;
  logic       a0;
  logic [7:0] din;
  logic [7:0] dout;
  logic       irq_n;

  int          cycles = 0;
  int          timeout_limit = 0;
  int unsigned lcg_state = SEED;

  // stimulus table, one timer run per row
  string      row_name      [NUM_ROWS];
  int         row_timer     [NUM_ROWS];
  logic [7:0] row_preset    [NUM_ROWS];
  logic       row_mask      [NUM_ROWS];
  int         row_status    [NUM_ROWS];
  logic       row_irq_n     [NUM_ROWS];

  opl_timer_top #(.tick_clks(TICK_CLKS)) UUT (
    .clk   (clk),
    .rst   (rst),
    .cs_n  (cs_n),
    .wr_n  (wr_n),
    .a0    (a0),
    .din   (din),
    .dout  (dout),
    .irq_n (irq_n)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // cycle count doubles as the run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (timeout_limit > 0 && cycles >= timeout_limit) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  function automatic logic [7:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic set_row(input int r, input string name, input int timer,
                         input logic [7:0] preset, input logic mask,
                         input int status, input logic irq_value);
    row_name[r]   = name;
    row_timer[r]  = timer;
    row_preset[r] = preset;
    row_mask[r]   = mask;
    row_status[r] = status;
    row_irq_n[r]  = irq_value;
  endtask

  // first two rows share a preset so timer 2 runs four times as long
  task automatic fill_table();
    set_row(0, "t1_unmasked", 1, 8'hF8, 1'b0, 'hC0, 1'b0);
    set_row(1, "t2_masked", 2, 8'hF8, 1'b1, 'hA0, 1'b1);
    set_row(2, "t1_masked_rand", 1, 8'hF0 | (next_random() & 8'h0F), 1'b1, 'hC0, 1'b1);
    set_row(3, "t2_unmasked_rand", 2, 8'hF0 | (next_random() & 8'h0F), 1'b0, 'hA0, 1'b0);
  endtask

  // clocks from start to the overflow pulse
  function automatic int row_period(input int r);
    int ticks;
    ticks = (row_timer[r] == 1) ? TICK_CLKS : TICK_CLKS * T2_RATIO;
    return (256 - int'(row_preset[r])) * ticks;
  endfunction

  task automatic check_equal(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("FAIL %s: expected %0d (0x%0h), actual %0d (0x%0h)",
               name, expected, expected, actual, actual);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // bus tasks are entered just after a rising edge
  task automatic bus_write(input logic addr, input logic [7:0] value);
    cs_n = 1'b0;
    wr_n = 1'b0;
    a0   = addr;
    din  = value;
    @(posedge clk);
    #DRIVE_DELAY;
    cs_n = 1'b1;
    wr_n = 1'b1;
    a0   = 1'b0;
    din  = 8'h00;
  endtask

  task automatic write_index(input logic [7:0] index);
    bus_write(1'b0, index);
  endtask

  task automatic write_data(input logic [7:0] value);
    bus_write(1'b1, value);
  endtask

  task automatic read_status(output logic [7:0] value, output logic irq_value,
                             output int at_cycle);
    cs_n = 1'b0;
    wr_n = 1'b1;
    a0   = 1'b0;
    #SAMPLE_DELAY;
    value     = dout;
    irq_value = irq_n;
    at_cycle  = cycles;
    @(posedge clk);
    #DRIVE_DELAY;
    cs_n = 1'b1;
  endtask

  task automatic wait_for_flag(input string name, input int start_cycle, input int bound,
                               output logic [7:0] value, output logic irq_value,
                               output int elapsed);
    int at_cycle;
    value   = 8'h00;
    elapsed = 0;
    while (value == 8'h00) begin
      read_status(value, irq_value, at_cycle);
      elapsed = at_cycle - start_cycle;
      if (value == 8'h00) begin
        assert (elapsed < bound) else begin
          $display("%s: no timer flag appeared within %0d cycles of the start", name, bound);
          $display("CHECKS FAILED");
          $fatal(1);
        end
      end
    end
  endtask

  initial begin
    logic [7:0] value;
    logic       irq_value;
    logic [7:0] index;
    logic [7:0] ctrl;
    int         at_cycle;
    int         start_cycle;
    int         elapsed;
    int         period;

    rst  = 1'b1;
    cs_n = 1'b1;
    wr_n = 1'b1;
    a0   = 1'b0;
    din  = 8'h00;
    fill_table();
    timeout_limit = 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      timeout_limit += 2 * row_period(r) + 4;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    read_status(value, irq_value, at_cycle);
    check_equal("reset status", 'h00, int'(value));
    check_equal("reset irq_n", 1, int'(irq_value));

    for (int r = 0; r < NUM_ROWS; r++) begin
      period = row_period(r);
      if (row_timer[r] == 1) begin
        ctrl = 8'h01 | (row_mask[r] ? 8'h40 : 8'h00);
      end else begin
        ctrl = 8'h02 | (row_mask[r] ? 8'h20 : 8'h00);
      end
      // stop everything, then program the preset
      write_index(8'h04);
      write_data(8'h00);
      write_index((row_timer[r] == 1) ? 8'h02 : 8'h03);
      write_data(row_preset[r]);
      // unused indices must not disturb anything
      for (int w = 0; w < UNUSED_WRITES; w++) begin
        index = next_random();
        while (index >= 8'h02 && index <= 8'h04) begin
          index = next_random();
        end
        write_index(index);
        write_data(next_random());
      end
      write_index(8'h04);
      write_data(8'h80);
      read_status(value, irq_value, at_cycle);
      check_equal({row_name[r], " idle status"}, 'h00, int'(value));
      check_equal({row_name[r], " idle irq_n"}, 1, int'(irq_value));

      write_data(ctrl);
      start_cycle = cycles;
      // flag lands one clock after the overflow pulse
      wait_for_flag(row_name[r], start_cycle, period + 4, value, irq_value, elapsed);
      check_equal({row_name[r], " first period"}, period + 1, elapsed);
      check_equal({row_name[r], " status"}, row_status[r], int'(value));
      check_equal({row_name[r], " irq_n"}, int'(row_irq_n[r]), int'(irq_value));

      // flag reset leaves the timer running
      write_data(8'h80);
      read_status(value, irq_value, at_cycle);
      check_equal({row_name[r], " status after flag reset"}, 'h00, int'(value));
      check_equal({row_name[r], " irq_n after flag reset"}, 1, int'(irq_value));
      wait_for_flag(row_name[r], start_cycle, 2 * period + 4, value, irq_value, elapsed);
      check_equal({row_name[r], " second period"}, 2 * period + 1, elapsed);
      check_equal({row_name[r], " second status"}, row_status[r], int'(value));
      check_equal({row_name[r], " second irq_n"}, int'(row_irq_n[r]), int'(irq_value));

      // deselected bus reads zero even with a flag up
      #SAMPLE_DELAY;
      check_equal({row_name[r], " dout with cs_n high"}, 'h00, int'(dout));
      @(posedge clk);
      #DRIVE_DELAY;
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/opl_timer_pkg.sv
source/opl_bus_decode.sv
source/opl_timer_regs.sv
source/opl_interval_timer.sv
source/opl_status_irq.sv
source/opl_timer_top.sv
bench/opl_timer_tb.sv

// ==== Makefile ====
# Verilator build and run for the OPL timer section

TOP := opl_timer_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check for a pass"
	@echo "  clean  remove the Verilator build directory"

# the run fails unless the pass line shows up in the output
test:
	verilator --binary --assert --timescale 1ns/1ps -f list.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
